// File: flist.f
+incdir+include
hdl/issue_pkg.sv
hdl/int_regfile.sv
hdl/issue_hazard_unit.sv
hdl/operand_dispatch.sv
hdl/issue_read_operands.sv
verif/issue_asserts.sv
verif/tb_issue_read_operands.sv

// File: hdl/int_regfile.sv
// Integer register file.
// Flop array with two asynchronous read ports and one write port per
// commit port. x0 is cleared on reset and never written.

`include "issue_macros.svh"

module int_regfile import issue_pkg::*; (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    // operand read ports
    input  reg_addr_t                            raddr_a_i,
    input  reg_addr_t                            raddr_b_i,
    output xlen_t                                rdata_a_o,
    output xlen_t                                rdata_b_o,
    // commit write ports
    input  reg_addr_t [`ISSUE_NR_COMMIT-1:0]     waddr_i,
    input  xlen_t     [`ISSUE_NR_COMMIT-1:0]     wdata_i,
    input  logic      [`ISSUE_NR_COMMIT-1:0]     we_i
);

    xlen_t mem_q [`ISSUE_NR_REGS];

    // ------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------

    // ports are walked in order, so the highest port wins a collision
    always_ff @(posedge clk_i or negedge rst_ni) begin : reg_write
        if (!rst_ni) begin
            for (int unsigned r = 0; r < `ISSUE_NR_REGS; r++) begin
                mem_q[r] <= '0;
            end
        end else begin
            for (int unsigned p = 0; p < `ISSUE_NR_COMMIT; p++) begin
                // x0 stays at zero
                if (we_i[p] && (waddr_i[p] != '0)) begin
                    mem_q[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------

    // same-cycle write is not bypassed, the old value is returned
    assign rdata_a_o = mem_q[raddr_a_i];
    assign rdata_b_o = mem_q[raddr_b_i];

endmodule

// File: hdl/issue_hazard_unit.sv
// Issue hazard unit.
// Looks up the clobber table for both sources and the destination,
// decides forwarding or stall, picks the busy level of the target unit
// and forms the issue acknowledge and the launch level. Combinational.

`include "issue_macros.svh"

module issue_hazard_unit import issue_pkg::*; (
    // decoded instruction
    input  logic                                 instr_valid_i,
    input  fu_t                                  instr_fu_i,
    input  reg_addr_t                            instr_rs1_i,
    input  reg_addr_t                            instr_rs2_i,
    input  reg_addr_t                            instr_rd_i,
    input  logic                                 instr_ex_valid_i,
    // scoreboard state
    input  logic                                 rs1_valid_i,
    input  logic                                 rs2_valid_i,
    input  fu_t       [`ISSUE_NR_REGS-1:0]       clobber_i,
    // commit ports, for the WAW bypass
    input  reg_addr_t [`ISSUE_NR_COMMIT-1:0]     waddr_i,
    input  logic      [`ISSUE_NR_COMMIT-1:0]     we_i,
    // unit readiness
    input  logic                                 flu_ready_i,
    input  logic                                 lsu_ready_i,
    input  logic                                 mult_pending_i,
    // decisions
    output logic                                 fwd_rs1_o,
    output logic                                 fwd_rs2_o,
    output logic                                 issue_ack_o,
    output logic                                 launch_o
);

    fu_t  rs1_clobber;
    fu_t  rs2_clobber;
    fu_t  rd_clobber;
    logic stall;
    logic fu_busy;
    logic rd_free;

    // pending writers of the registers this instruction touches
    assign rs1_clobber = clobber_i[instr_rs1_i];
    assign rs2_clobber = clobber_i[instr_rs2_i];
    assign rd_clobber  = clobber_i[instr_rd_i];

    // ------------------------------------------------------------------
    // source operands
    // ------------------------------------------------------------------

    // a pending source is taken from the scoreboard once its result is
    // valid; CSR results are only reachable through the register file
    always_comb begin : operand_hazard
        stall     = 1'b0;
        fwd_rs1_o = 1'b0;
        fwd_rs2_o = 1'b0;
        if (rs1_clobber != NONE) begin
            if (rs1_valid_i && (rs1_clobber != CSR)) begin
                fwd_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rs2_clobber != NONE) begin
            if (rs2_valid_i && (rs2_clobber != CSR)) begin
                fwd_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // busy level of the unit the instruction needs
    always_comb begin : unit_busy
        case (instr_fu_i)
            ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // WAW check and acknowledge
    // ------------------------------------------------------------------

    // rd is free when nobody writes it or a commit retires it right now
    always_comb begin : waw_check
        rd_free = (rd_clobber == NONE);
        for (int unsigned p = 0; p < `ISSUE_NR_COMMIT; p++) begin
            if (we_i[p] && (waddr_i[p] == instr_rd_i)) begin
                rd_free = 1'b1;
            end
        end
    end

    always_comb begin : issue_ack
        issue_ack_o = 1'b0;
        if (instr_valid_i) begin
            if (!stall && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less instructions pass straight through
            if (instr_ex_valid_i || (instr_fu_i == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // a multiply in flight owns the fixed latency writeback next cycle
        if (mult_pending_i && (instr_fu_i != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    // only exception-free instructions start a unit
    assign launch_o = issue_ack_o & ~instr_ex_valid_i;

endmodule

// File: hdl/issue_pkg.sv
// Issue stage package.
// Vector types for data, register indices and scoreboard tags,
// plus the functional unit encoding used by the clobber table.

`include "issue_macros.svh"

package issue_pkg;

    // ------------------------------------------------------------------
    // plain vector types
    // ------------------------------------------------------------------

    // one integer data word
    typedef logic [`ISSUE_XLEN-1:0] xlen_t;

    // integer register index
    typedef logic [`ISSUE_REG_AW-1:0] reg_addr_t;

    // scoreboard tag, travels with the instruction into execute
    typedef logic [`ISSUE_TRANS_ID_W-1:0] trans_id_t;

    // operation code, opaque to this stage
    typedef logic [6:0] fu_op_t;

    // ------------------------------------------------------------------
    // functional units
    // ------------------------------------------------------------------

    // NONE in the clobber table means no writer is pending
    typedef enum logic [2:0] {
        NONE,
        LOAD,
        STORE,
        ALU,
        CTRL_FLOW,
        MULT,
        CSR
    } fu_t;

endpackage

// File: hdl/issue_read_operands.sv
// Issue and operand read stage.
// Checks the decoded instruction against the scoreboard, reads the
// integer register file and hands operands to the functional units
// through the ID/EX register.

`include "issue_macros.svh"

module issue_read_operands import issue_pkg::*; (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 flush_i,
    // decoded instruction
    input  logic                                 instr_valid_i,
    input  fu_t                                  instr_fu_i,
    input  fu_op_t                               instr_op_i,
    input  reg_addr_t                            instr_rs1_i,
    input  reg_addr_t                            instr_rs2_i,
    input  reg_addr_t                            instr_rd_i,
    input  xlen_t                                instr_imm_i,
    input  xlen_t                                instr_pc_i,
    input  logic                                 instr_use_imm_i,
    input  logic                                 instr_use_pc_i,
    input  logic                                 instr_ex_valid_i,
    input  trans_id_t                            instr_trans_id_i,
    output logic                                 issue_ack_o,
    // scoreboard lookup
    output reg_addr_t                            rs1_o,
    input  xlen_t                                rs1_i,
    input  logic                                 rs1_valid_i,
    output reg_addr_t                            rs2_o,
    input  xlen_t                                rs2_i,
    input  logic                                 rs2_valid_i,
    input  fu_t       [`ISSUE_NR_REGS-1:0]       clobber_i,
    // unit readiness
    input  logic                                 flu_ready_i,
    input  logic                                 lsu_ready_i,
    // commit
    input  reg_addr_t [`ISSUE_NR_COMMIT-1:0]     waddr_i,
    input  xlen_t     [`ISSUE_NR_COMMIT-1:0]     wdata_i,
    input  logic      [`ISSUE_NR_COMMIT-1:0]     we_i,
    // to the functional units
    output xlen_t                                operand_a_o,
    output xlen_t                                operand_b_o,
    output xlen_t                                imm_o,
    output fu_t                                  fu_o,
    output fu_op_t                               op_o,
    output trans_id_t                            trans_id_o,
    output xlen_t                                pc_o,
    output logic                                 alu_valid_o,
    output logic                                 branch_valid_o,
    output logic                                 lsu_valid_o,
    output logic                                 mult_valid_o,
    output logic                                 csr_valid_o
);

    logic  fwd_rs1;
    logic  fwd_rs2;
    logic  launch;
    logic  mult_pending;
    xlen_t rf_rdata_a;
    xlen_t rf_rdata_b;

    // scoreboard is polled with the raw source indices
    assign rs1_o = instr_rs1_i;
    assign rs2_o = instr_rs2_i;

    issue_hazard_unit i_issue_hazard_unit (
        .instr_valid_i    ( instr_valid_i    ),
        .instr_fu_i       ( instr_fu_i       ),
        .instr_rs1_i      ( instr_rs1_i      ),
        .instr_rs2_i      ( instr_rs2_i      ),
        .instr_rd_i       ( instr_rd_i       ),
        .instr_ex_valid_i ( instr_ex_valid_i ),
        .rs1_valid_i      ( rs1_valid_i      ),
        .rs2_valid_i      ( rs2_valid_i      ),
        .clobber_i        ( clobber_i        ),
        .waddr_i          ( waddr_i          ),
        .we_i             ( we_i             ),
        .flu_ready_i      ( flu_ready_i      ),
        .lsu_ready_i      ( lsu_ready_i      ),
        .mult_pending_i   ( mult_pending     ),
        .fwd_rs1_o        ( fwd_rs1          ),
        .fwd_rs2_o        ( fwd_rs2          ),
        .issue_ack_o      ( issue_ack_o      ),
        .launch_o         ( launch           )
    );

    int_regfile i_int_regfile (
        .clk_i     ( clk_i       ),
        .rst_ni    ( rst_ni      ),
        .raddr_a_i ( instr_rs1_i ),
        .raddr_b_i ( instr_rs2_i ),
        .rdata_a_o ( rf_rdata_a  ),
        .rdata_b_o ( rf_rdata_b  ),
        .waddr_i   ( waddr_i     ),
        .wdata_i   ( wdata_i     ),
        .we_i      ( we_i        )
    );

    operand_dispatch i_operand_dispatch (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .flush_i          ( flush_i          ),
        .launch_i         ( launch           ),
        .fwd_rs1_i        ( fwd_rs1          ),
        .fwd_rs2_i        ( fwd_rs2          ),
        .rf_rdata_a_i     ( rf_rdata_a       ),
        .rf_rdata_b_i     ( rf_rdata_b       ),
        .rs1_i            ( rs1_i            ),
        .rs2_i            ( rs2_i            ),
        .instr_fu_i       ( instr_fu_i       ),
        .instr_op_i       ( instr_op_i       ),
        .instr_imm_i      ( instr_imm_i      ),
        .instr_pc_i       ( instr_pc_i       ),
        .instr_use_imm_i  ( instr_use_imm_i  ),
        .instr_use_pc_i   ( instr_use_pc_i   ),
        .instr_trans_id_i ( instr_trans_id_i ),
        .operand_a_o      ( operand_a_o      ),
        .operand_b_o      ( operand_b_o      ),
        .imm_o            ( imm_o            ),
        .fu_o             ( fu_o             ),
        .op_o             ( op_o             ),
        .trans_id_o       ( trans_id_o       ),
        .pc_o             ( pc_o             ),
        .alu_valid_o      ( alu_valid_o      ),
        .branch_valid_o   ( branch_valid_o   ),
        .lsu_valid_o      ( lsu_valid_o      ),
        .mult_valid_o     ( mult_valid_o     ),
        .csr_valid_o      ( csr_valid_o      ),
        .mult_pending_o   ( mult_pending     )
    );

endmodule

// File: hdl/operand_dispatch.sv
// Operand dispatch.
// Selects operand A and B from the register file, the scoreboard, the
// PC or the immediate, registers them with the instruction fields into
// the ID/EX register and raises one valid strobe per functional unit.

module operand_dispatch import issue_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    // from the hazard unit
    input  logic      launch_i,
    input  logic      fwd_rs1_i,
    input  logic      fwd_rs2_i,
    // operand sources
    input  xlen_t     rf_rdata_a_i,
    input  xlen_t     rf_rdata_b_i,
    input  xlen_t     rs1_i,
    input  xlen_t     rs2_i,
    // instruction fields
    input  fu_t       instr_fu_i,
    input  fu_op_t    instr_op_i,
    input  xlen_t     instr_imm_i,
    input  xlen_t     instr_pc_i,
    input  logic      instr_use_imm_i,
    input  logic      instr_use_pc_i,
    input  trans_id_t instr_trans_id_i,
    // ID/EX register
    output xlen_t     operand_a_o,
    output xlen_t     operand_b_o,
    output xlen_t     imm_o,
    output fu_t       fu_o,
    output fu_op_t    op_o,
    output trans_id_t trans_id_o,
    output xlen_t     pc_o,
    // unit strobes
    output logic      alu_valid_o,
    output logic      branch_valid_o,
    output logic      lsu_valid_o,
    output logic      mult_valid_o,
    output logic      csr_valid_o,
    output logic      mult_pending_o
);

    xlen_t operand_a_d;
    xlen_t operand_b_d;

    // ------------------------------------------------------------------
    // operand select
    // ------------------------------------------------------------------

    always_comb begin : operand_select
        operand_a_d = fwd_rs1_i ? rs1_i : rf_rdata_a_i;
        // auipc, jal and friends take the PC
        if (instr_use_pc_i) begin
            operand_a_d = instr_pc_i;
        end
        operand_b_d = fwd_rs2_i ? rs2_i : rf_rdata_b_i;
        // stores and branches keep rs2 and carry the immediate separately
        if (instr_use_imm_i && (instr_fu_i != STORE) && (instr_fu_i != CTRL_FLOW)) begin
            operand_b_d = instr_imm_i;
        end
    end

    // ------------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------------

    // loads every cycle, only meaningful under a strobe
    always_ff @(posedge clk_i or negedge rst_ni) begin : id_ex_reg
        if (!rst_ni) begin
            operand_a_o <= '0;
            operand_b_o <= '0;
            imm_o       <= '0;
            fu_o        <= NONE;
            op_o        <= '0;
            trans_id_o  <= '0;
            pc_o        <= '0;
        end else begin
            operand_a_o <= operand_a_d;
            operand_b_o <= operand_b_d;
            imm_o       <= instr_imm_i;
            fu_o        <= instr_fu_i;
            op_o        <= instr_op_i;
            trans_id_o  <= instr_trans_id_i;
            pc_o        <= instr_pc_i;
        end
    end

    // one strobe per unit, one cycle after launch; flush kills it
    always_ff @(posedge clk_i or negedge rst_ni) begin : unit_strobes
        if (!rst_ni) begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            lsu_valid_o    <= 1'b0;
            mult_valid_o   <= 1'b0;
            csr_valid_o    <= 1'b0;
        end else begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            lsu_valid_o    <= 1'b0;
            mult_valid_o   <= 1'b0;
            csr_valid_o    <= 1'b0;
            if (launch_i && !flush_i) begin
                case (instr_fu_i)
                    ALU:         alu_valid_o    <= 1'b1;
                    CTRL_FLOW:   branch_valid_o <= 1'b1;
                    LOAD, STORE: lsu_valid_o    <= 1'b1;
                    MULT:        mult_valid_o   <= 1'b1;
                    CSR:         csr_valid_o    <= 1'b1;
                    default:     ;
                endcase
            end
        end
    end

    // the multiplier result lands on the shared writeback next cycle
    assign mult_pending_o = mult_valid_o;

endmodule

// File: include/issue_macros.svh
// Issue stage configuration macros.
// Register file size, data width, commit port count and the
// scoreboard tag width shared by the package and all RTL blocks.

`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// integer register file geometry
`define ISSUE_NR_REGS 32
`define ISSUE_REG_AW 5

// datapath width
`define ISSUE_XLEN 32

// number of commit write ports into the register file
`define ISSUE_NR_COMMIT 2

// scoreboard transaction id width
`define ISSUE_TRANS_ID_W 3

`endif

// File: verif/issue_asserts.sv
// Issue stage assertions.
// Bound into the top level. Checks that at most one unit strobe fires,
// that a flush suppresses the next strobe, and that an acknowledge
// always belongs to a valid instruction.

module issue_asserts import issue_pkg::*; (
    input logic clk_i,
    input logic rst_ni,
    input logic flush_i,
    input logic instr_valid_i,
    input logic issue_ack_o,
    input logic alu_valid_o,
    input logic branch_valid_o,
    input logic lsu_valid_o,
    input logic mult_valid_o,
    input logic csr_valid_o
);

    logic [4:0] strobes;

    // number of failed assertions
    int unsigned n_fails = 0;

    assign strobes = {alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o};

    // one instruction per cycle, so one unit at most
    strobe_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(strobes))
        else begin
            n_fails++;
            $error("more than one unit strobe is high");
        end

    // flushed launches never reach a unit
    flush_kills_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> (strobes == '0))
        else begin
            n_fails++;
            $error("unit strobe high after a flush");
        end

    ack_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_ack_o |-> instr_valid_i)
        else begin
            n_fails++;
            $error("issue acknowledge without a valid instruction");
        end

endmodule

bind issue_read_operands issue_asserts i_issue_asserts (.*);

// File: verif/tb_issue_read_operands.sv
// Testbench for the issue and operand read stage.
// Drives LFSR random instructions, scoreboard state and commits, keeps a
// model of the register file and the issue rules, and checks the
// acknowledge, the unit strobes and the ID/EX operands every cycle.

`include "issue_macros.svh"

module tb_issue_read_operands import issue_pkg::*; ();

    localparam int unsigned N_CYCLES   = 2000;
    localparam int unsigned CLK_PERIOD = 100;

    logic                                clk_i;
    logic                                rst_ni;
    logic                                flush_i;
    logic                                instr_valid_i;
    fu_t                                 instr_fu_i;
    fu_op_t                              instr_op_i;
    reg_addr_t                           instr_rs1_i, instr_rs2_i, instr_rd_i;
    xlen_t                               instr_imm_i, instr_pc_i;
    logic                                instr_use_imm_i, instr_use_pc_i;
    logic                                instr_ex_valid_i;
    trans_id_t                           instr_trans_id_i;
    logic                                issue_ack_o;
    reg_addr_t                           rs1_o, rs2_o;
    xlen_t                               rs1_i, rs2_i;
    logic                                rs1_valid_i, rs2_valid_i;
    fu_t       [`ISSUE_NR_REGS-1:0]      clobber_i;
    logic                                flu_ready_i, lsu_ready_i;
    reg_addr_t [`ISSUE_NR_COMMIT-1:0]    waddr_i;
    xlen_t     [`ISSUE_NR_COMMIT-1:0]    wdata_i;
    logic      [`ISSUE_NR_COMMIT-1:0]    we_i;
    xlen_t                               operand_a_o, operand_b_o, imm_o, pc_o;
    fu_t                                 fu_o;
    fu_op_t                              op_o;
    trans_id_t                           trans_id_o;
    logic                                alu_valid_o, branch_valid_o, lsu_valid_o;
    logic                                mult_valid_o, csr_valid_o;

    // model state
    logic [31:0] lfsr;
    xlen_t       model_rf [`ISSUE_NR_REGS];
    // strobe order alu, branch, lsu, mult, csr
    logic [4:0]  exp_strobes;
    xlen_t       exp_a, exp_b, exp_imm, exp_pc;
    fu_t         exp_fu;
    fu_op_t      exp_op;
    trans_id_t   exp_tid;
    logic        hold;
    int unsigned n_checks, n_errors;

    issue_read_operands i_issue_read_operands (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // random source
    // ------------------------------------------------------------------

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic fu_t rand_fu();
        logic [2:0] v;
        v = 3'(rand_bits(3) % 7);
        return fu_t'(v);
    endfunction

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------

    // a stalled instruction is held, everything around it is redrawn
    task automatic drive_inputs();
        if (!hold) begin
            instr_valid_i    <= (rand_bits(3) != 0);
            instr_fu_i       <= rand_fu();
            instr_op_i       <= fu_op_t'(rand_bits(7));
            instr_rs1_i      <= reg_addr_t'(rand_bits(5));
            instr_rs2_i      <= reg_addr_t'(rand_bits(5));
            instr_rd_i       <= reg_addr_t'(rand_bits(5));
            instr_imm_i      <= rand_bits(32);
            instr_pc_i       <= rand_bits(32);
            instr_use_imm_i  <= (rand_bits(1) != 0);
            instr_use_pc_i   <= (rand_bits(2) == 0);
            instr_ex_valid_i <= (rand_bits(3) == 0);
            instr_trans_id_i <= trans_id_t'(rand_bits(3));
        end
        // about one register in four has a writer in flight
        for (int unsigned r = 0; r < `ISSUE_NR_REGS; r++) begin
            if (rand_bits(2) == 0) begin
                clobber_i[r] <= rand_fu();
            end else begin
                clobber_i[r] <= NONE;
            end
        end
        rs1_i       <= rand_bits(32);
        rs2_i       <= rand_bits(32);
        rs1_valid_i <= (rand_bits(1) != 0);
        rs2_valid_i <= (rand_bits(1) != 0);
        flu_ready_i <= (rand_bits(2) != 0);
        lsu_ready_i <= (rand_bits(2) != 0);
        for (int unsigned p = 0; p < `ISSUE_NR_COMMIT; p++) begin
            we_i[p]    <= (rand_bits(1) != 0);
            waddr_i[p] <= reg_addr_t'(rand_bits(5));
            wdata_i[p] <= rand_bits(32);
        end
        // rare flush
        flush_i <= (rand_bits(5) == 0);
    endtask

    // ------------------------------------------------------------------
    // checking and model
    // ------------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // registered outputs reflect the previous cycle's expectation
    task automatic check_outputs();
        check_value("strobes", exp_strobes,
                    {alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o});
        if (exp_strobes != '0) begin
            check_value("operand_a_o", exp_a, operand_a_o);
            check_value("operand_b_o", exp_b, operand_b_o);
            check_value("imm_o", exp_imm, imm_o);
            check_value("fu_o", exp_fu, fu_o);
            check_value("op_o", exp_op, op_o);
            check_value("trans_id_o", exp_tid, trans_id_o);
            check_value("pc_o", exp_pc, pc_o);
        end
    endtask

    task automatic model_cycle();
        fu_t  c1, c2, crd;
        logic fwd1, fwd2, stall, busy, rd_free, ack;
        c1 = clobber_i[instr_rs1_i];
        c2 = clobber_i[instr_rs2_i];
        crd = clobber_i[instr_rd_i];
        // scoreboard data is usable when valid and not from a CSR
        fwd1 = (c1 != NONE) && rs1_valid_i && (c1 != CSR);
        fwd2 = (c2 != NONE) && rs2_valid_i && (c2 != CSR);
        stall = ((c1 != NONE) && !fwd1) || ((c2 != NONE) && !fwd2);
        case (instr_fu_i)
            ALU, CTRL_FLOW, CSR, MULT: busy = !flu_ready_i;
            LOAD, STORE:               busy = !lsu_ready_i;
            default:                   busy = 1'b0;
        endcase
        rd_free = (crd == NONE);
        for (int unsigned p = 0; p < `ISSUE_NR_COMMIT; p++) begin
            if (we_i[p] && (waddr_i[p] == instr_rd_i)) begin
                rd_free = 1'b1;
            end
        end
        ack = instr_valid_i && ((!stall && !busy && rd_free) || instr_ex_valid_i ||
                                (instr_fu_i == NONE));
        // mult strobe high now means the multiplier holds writeback
        if (exp_strobes[1] && (instr_fu_i != MULT)) begin
            ack = 1'b0;
        end
        check_value("issue_ack_o", ack, issue_ack_o);
        check_value("rs1_o", instr_rs1_i, rs1_o);
        check_value("rs2_o", instr_rs2_i, rs2_o);

        exp_strobes = '0;
        if (ack && !instr_ex_valid_i && !flush_i) begin
            case (instr_fu_i)
                ALU:         exp_strobes = 5'b10000;
                CTRL_FLOW:   exp_strobes = 5'b01000;
                LOAD, STORE: exp_strobes = 5'b00100;
                MULT:        exp_strobes = 5'b00010;
                CSR:         exp_strobes = 5'b00001;
                default:     exp_strobes = 5'b00000;
            endcase
        end
        exp_a = instr_use_pc_i ? instr_pc_i : (fwd1 ? rs1_i : model_rf[instr_rs1_i]);
        exp_b = fwd2 ? rs2_i : model_rf[instr_rs2_i];
        if (instr_use_imm_i && (instr_fu_i != STORE) && (instr_fu_i != CTRL_FLOW)) begin
            exp_b = instr_imm_i;
        end
        exp_imm = instr_imm_i;
        exp_fu  = instr_fu_i;
        exp_op  = instr_op_i;
        exp_tid = instr_trans_id_i;
        exp_pc  = instr_pc_i;
        // commits land at the coming edge, after this cycle's read
        for (int unsigned p = 0; p < `ISSUE_NR_COMMIT; p++) begin
            if (we_i[p] && (waddr_i[p] != '0)) begin
                model_rf[waddr_i[p]] = wdata_i[p];
            end
        end
        hold = instr_valid_i && !ack;
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------

    initial begin : main_seq
        clk_i = 1'b0;
        rst_ni = 1'b0;
        flush_i = 1'b0;
        instr_valid_i = 1'b0;
        instr_fu_i = NONE;
        instr_op_i = '0;
        instr_rs1_i = '0;
        instr_rs2_i = '0;
        instr_rd_i = '0;
        instr_imm_i = '0;
        instr_pc_i = '0;
        instr_use_imm_i = 1'b0;
        instr_use_pc_i = 1'b0;
        instr_ex_valid_i = 1'b0;
        instr_trans_id_i = '0;
        rs1_i = '0;
        rs2_i = '0;
        rs1_valid_i = 1'b0;
        rs2_valid_i = 1'b0;
        clobber_i = {`ISSUE_NR_REGS{NONE}};
        flu_ready_i = 1'b0;
        lsu_ready_i = 1'b0;
        waddr_i = '0;
        wdata_i = '0;
        we_i = '0;
        lfsr = 32'd44;
        hold = 1'b0;
        exp_strobes = '0;
        n_checks = 0;
        n_errors = 0;
        for (int unsigned r = 0; r < `ISSUE_NR_REGS; r++) begin
            model_rf[r] = '0;
        end

        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        check_value("strobes", 5'b00000,
                    {alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o});
        check_value("fu_o", NONE, fu_o);
        @(posedge clk_i);
        rst_ni <= 1'b1;

        repeat (N_CYCLES) begin
            @(posedge clk_i);
            drive_inputs();
            @(negedge clk_i);
            check_outputs();
            model_cycle();
        end

        $display("checks: %0d, errors: %0d, assertion failures: %0d", n_checks, n_errors,
                 i_issue_read_operands.i_issue_asserts.n_fails);
        if ((n_errors == 0) && (i_issue_read_operands.i_issue_asserts.n_fails == 0)) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // stimulus length plus a margin
    initial begin : watchdog
        #((N_CYCLES + 50) * CLK_PERIOD);
        $display("watchdog expired before the test sequence completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
